/* logic/muldiv_pkg.sv */
`default_nettype none

// shared widths and types for the hi/lo multiply-divide unit
package muldiv_pkg;

    localparam int word_w     = 32;                 // data word width
    localparam int mul_stages = 3;                  // multiplier register stages
    localparam int div_steps  = 32;                 // one quotient bit per step
    localparam int div_cnt_w  = $clog2(div_steps);  // step counter width

    typedef logic [word_w-1:0]   word_t;
    typedef logic [word_w:0]     ext_word_t;        // extra top bit carries sign or zero
    typedef logic [2*word_w-1:0] dword_t;           // full product
    typedef logic [div_cnt_w-1:0] div_cnt_t;

    // last step index of the divider loop
    localparam div_cnt_t div_last = div_cnt_t'(div_steps - 1);

    // operation codes
    typedef enum logic [2:0]
    {
        op_mult  = 3'd0,    // signed multiply
        op_multu = 3'd1,    // unsigned multiply
        op_div   = 3'd2,    // signed divide
        op_divu  = 3'd3,    // unsigned divide
        op_mthi  = 3'd4,    // a -> hi
        op_mtlo  = 3'd5     // a -> lo
    } md_op_e;

    // one request, valid is a single-cycle strobe
    typedef struct packed
    {
        logic   valid;
        md_op_e op;
        word_t  a;      // multiplicand / dividend / move data
        word_t  b;      // multiplier / divisor
    } md_req_t;

    // write-back into hi and lo, each half has its own enable
    typedef struct packed
    {
        logic  hi_en;
        logic  lo_en;
        word_t hi;      // product high half or remainder
        word_t lo;      // product low half or quotient
    } hilo_wr_t;

endpackage

`default_nettype wire

/* logic/mul_pipe.sv */
`default_nettype none

// three-stage 33x33 signed multiplier, operands already extended by the caller
module mul_pipe
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  flush,     // drops everything in flight
    input  wire logic                  start,
    input  wire muldiv_pkg::ext_word_t a,
    input  wire muldiv_pkg::ext_word_t b,
    output muldiv_pkg::hilo_wr_t       wb
);

    logic [muldiv_pkg::mul_stages-1:0] vld;     // valid bit per stage
    logic signed [50:0] pp_lo;                  // a * b[16:0], 33 + 18 bits
    logic signed [48:0] pp_hi;                  // a * b[32:17], 33 + 16 bits
    muldiv_pkg::dword_t prod;                   // stage 2 sum
    muldiv_pkg::dword_t res;                    // stage 3 result

    // valid chain, shifts one stage per edge
    always_ff @(posedge clk)
    begin
        if (reset || flush)
            vld <= '0;
        else
            vld <= {vld[muldiv_pkg::mul_stages-2:0], start};
    end

    // stage 1: split b, low part taken as unsigned
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            pp_lo <= $signed(a) * $signed({1'b0, b[16:0]});
            pp_hi <= $signed(a) * $signed(b[32:17]);
        end
    end

    // stage 2: realign the high partial product and add
    // only the low 64 bits are kept, the full product fits there
    always_ff @(posedge clk)
    begin
        if (vld[0])
            prod <= ({{15{pp_hi[48]}}, pp_hi} << 17) + {{13{pp_lo[50]}}, pp_lo};
    end

    // stage 3: output register
    always_ff @(posedge clk)
    begin
        if (vld[1])
            res <= prod;
    end

    always_comb
    begin
        wb.hi_en = vld[muldiv_pkg::mul_stages-1] & ~flush;   // cancelled on flush
        wb.lo_en = vld[muldiv_pkg::mul_stages-1] & ~flush;
        wb.hi    = res[2*muldiv_pkg::word_w-1:muldiv_pkg::word_w];
        wb.lo    = res[muldiv_pkg::word_w-1:0];
    end

endmodule

`default_nettype wire

/* logic/radix2_divider.sv */
`default_nettype none

// restoring divider, one quotient bit per cycle
// load, 32 steps, sign fix, then a one-cycle done
module radix2_divider
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              flush,       // back to idle, no write-back
    input  wire logic              start,       // only looked at in idle
    input  wire logic              signed_op,
    input  wire muldiv_pkg::word_t dividend,
    input  wire muldiv_pkg::word_t divisor,
    output muldiv_pkg::hilo_wr_t   wb           // quotient in lo, remainder in hi
);

    typedef enum logic [1:0]
    {
        st_idle,
        st_run,
        st_fix
    } div_state_e;

    div_state_e state;
    muldiv_pkg::div_cnt_t step_cnt;
    logic done;                                 // single-cycle result strobe

    muldiv_pkg::word_t rem;                     // partial remainder
    muldiv_pkg::word_t quo;                     // dividend shifting out, quotient in
    muldiv_pkg::word_t dsr;                     // divisor magnitude
    logic neg_q;                                // negate quotient at the end
    logic neg_r;                                // negate remainder at the end

    logic dvd_neg;
    logic dsr_neg;
    muldiv_pkg::word_t dvd_mag;
    muldiv_pkg::word_t dsr_mag;
    logic [muldiv_pkg::word_w+1:0] trial;       // shifted remainder minus divisor

    always_comb
    begin
        dvd_neg = signed_op & dividend[muldiv_pkg::word_w-1];
        dsr_neg = signed_op & divisor[muldiv_pkg::word_w-1];
        dvd_mag = dvd_neg ? -dividend : dividend;   // 0x8000_0000 stays as is, fine unsigned
        dsr_mag = dsr_neg ? -divisor : divisor;
        // top bit set means borrow, keep the old remainder
        trial = {1'b0, rem, quo[muldiv_pkg::word_w-1]} - {2'b00, dsr};
    end

    // control
    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            state    <= st_idle;
            step_cnt <= '0;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (start)
                    begin
                        state    <= st_run;
                        step_cnt <= '0;
                    end
                end
                st_run:
                begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == muldiv_pkg::div_last)
                        state <= st_fix;
                end
                st_fix:
                begin
                    state <= st_idle;
                    done  <= 1'b1;              // result valid next cycle
                end
                default: state <= st_idle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk)
    begin
        case (state)
            st_idle:
            begin
                if (start)
                begin
                    rem   <= '0;
                    quo   <= dvd_mag;
                    dsr   <= dsr_mag;
                    neg_q <= dvd_neg ^ dsr_neg;     // quotient sign
                    neg_r <= dvd_neg;               // remainder follows dividend
                end
            end
            st_run:
            begin
                if (trial[muldiv_pkg::word_w+1])
                begin
                    rem <= {rem[muldiv_pkg::word_w-2:0], quo[muldiv_pkg::word_w-1]};
                    quo <= {quo[muldiv_pkg::word_w-2:0], 1'b0};
                end
                else
                begin
                    rem <= trial[muldiv_pkg::word_w-1:0];
                    quo <= {quo[muldiv_pkg::word_w-2:0], 1'b1};
                end
            end
            st_fix:
            begin
                if (neg_q)
                    quo <= -quo;
                if (neg_r)
                    rem <= -rem;
            end
            default: ;
        endcase
    end

    always_comb
    begin
        wb.hi_en = done & ~flush;
        wb.lo_en = done & ~flush;
        wb.hi    = rem;
        wb.lo    = quo;
    end

endmodule

`default_nettype wire

/* logic/hilo_regs.sv */
`default_nettype none

// hi and lo registers with a fixed-priority write merge and write-through reads
module hilo_regs
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire muldiv_pkg::hilo_wr_t div_wb,     // highest priority
    input  wire muldiv_pkg::hilo_wr_t mul_wb,
    input  wire muldiv_pkg::hilo_wr_t move_wb,    // lowest priority
    input  wire logic                 rd_lo,      // 1 reads lo, 0 reads hi
    output muldiv_pkg::word_t         rd_data
);

    muldiv_pkg::hilo_wr_t wr;                     // merged write this cycle
    muldiv_pkg::word_t hi_q;
    muldiv_pkg::word_t lo_q;
    muldiv_pkg::word_t hi_rd;                     // hi as seen by a read
    muldiv_pkg::word_t lo_rd;

    // busy upstream keeps these exclusive, priority only as a safety net
    always_comb
    begin
        if (div_wb.hi_en || div_wb.lo_en)
            wr = div_wb;
        else if (mul_wb.hi_en || mul_wb.lo_en)
            wr = mul_wb;
        else
            wr = move_wb;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hi_q <= '0;
            lo_q <= '0;
        end
        else
        begin
            if (wr.hi_en)
                hi_q <= wr.hi;
            if (wr.lo_en)
                lo_q <= wr.lo;
        end
    end

    // pending write wins over the stored value
    always_comb
    begin
        hi_rd   = wr.hi_en ? wr.hi : hi_q;
        lo_rd   = wr.lo_en ? wr.lo : lo_q;
        rd_data = rd_lo ? lo_rd : hi_rd;
    end

endmodule

`default_nettype wire

/* logic/muldiv_unit.sv */
`default_nettype none

// hi/lo arithmetic unit: multiplier and divider side by side,
// results merged with the move writes in the register block
module muldiv_unit
(
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire muldiv_pkg::md_req_t req,
    input  wire logic                flush,      // cancels a mul or div in flight
    input  wire logic                rd_lo,
    output logic                     busy,
    output muldiv_pkg::word_t        rd_data
);

    logic accept;           // request taken this cycle
    logic is_mul;
    logic is_div;
    logic signed_op;
    logic mul_start;
    logic div_start;

    muldiv_pkg::ext_word_t ext_a;
    muldiv_pkg::ext_word_t ext_b;
    muldiv_pkg::hilo_wr_t  mul_wb;
    muldiv_pkg::hilo_wr_t  div_wb;
    muldiv_pkg::hilo_wr_t  move_wb;

    // decode
    always_comb
    begin
        accept    = req.valid & ~busy;   // no queue, dropped while busy
        is_mul    = (req.op == muldiv_pkg::op_mult) || (req.op == muldiv_pkg::op_multu);
        is_div    = (req.op == muldiv_pkg::op_div) || (req.op == muldiv_pkg::op_divu);
        signed_op = (req.op == muldiv_pkg::op_mult) || (req.op == muldiv_pkg::op_div);
        mul_start = accept & is_mul;
        div_start = accept & is_div;

        // sign or zero extension to 33 bits
        ext_a = {signed_op & req.a[muldiv_pkg::word_w-1], req.a};
        ext_b = {signed_op & req.b[muldiv_pkg::word_w-1], req.b};

        // moves write at the next edge, both halves carry a
        move_wb.hi_en = accept & (req.op == muldiv_pkg::op_mthi);
        move_wb.lo_en = accept & (req.op == muldiv_pkg::op_mtlo);
        move_wb.hi    = req.a;
        move_wb.lo    = req.a;
    end

    // busy covers a mul or div from acceptance to write-back
    always_ff @(posedge clk)
    begin
        if (reset || flush)
            busy <= 1'b0;
        else if (mul_wb.hi_en || div_wb.hi_en)
            busy <= 1'b0;                    // falls on the write edge
        else if (mul_start || div_start)
            busy <= 1'b1;
    end

    mul_pipe u_mul
    (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .start (mul_start),
        .a     (ext_a),
        .b     (ext_b),
        .wb    (mul_wb)
    );

    radix2_divider u_div
    (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .start     (div_start),
        .signed_op (signed_op),
        .dividend  (req.a),
        .divisor   (req.b),
        .wb        (div_wb)
    );

    hilo_regs u_hilo
    (
        .clk     (clk),
        .reset   (reset),
        .div_wb  (div_wb),
        .mul_wb  (mul_wb),
        .move_wb (move_wb),
        .rd_lo   (rd_lo),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* verif/muldiv_properties.sv */
`default_nettype none

// protocol checks on the hi/lo unit, bound into muldiv_unit
module muldiv_properties
(
    input wire logic                 clk,
    input wire logic                 reset,
    input wire logic                 flush,
    input wire logic                 busy,
    input wire logic                 mul_start,    // accepted multiply
    input wire logic                 div_start,    // accepted divide
    input wire muldiv_pkg::hilo_wr_t mul_wb,
    input wire muldiv_pkg::hilo_wr_t div_wb,
    input wire muldiv_pkg::hilo_wr_t move_wb
);

    int fail_cnt;       // failed assertions so far

    initial
        fail_cnt = 0;

    // busy is clear once reset has been seen
    busy_after_reset: assert property (@(posedge clk) reset |=> !busy)
    else
    begin
        fail_cnt++;
        $error("busy is high after reset");
    end

    // multiply: busy on the edge after acceptance, falls mul_stages edges later
    mul_latency: assert property (@(posedge clk) disable iff (reset || flush)
        mul_start |=> busy ##(muldiv_pkg::mul_stages) $fell(busy))
    else
    begin
        fail_cnt++;
        $error("busy did not fall at the multiply write-back edge");
    end

    // divide: load, div_steps steps, sign fix
    div_latency: assert property (@(posedge clk) disable iff (reset || flush)
        div_start |=> busy ##(muldiv_pkg::div_steps + 2) $fell(busy))
    else
    begin
        fail_cnt++;
        $error("busy did not fall at the divide write-back edge");
    end

    flush_clears_busy: assert property (@(posedge clk) disable iff (reset)
        flush |=> !busy)
    else
    begin
        fail_cnt++;
        $error("busy still high after a flush");
    end

    // at most one write-back source per cycle
    single_writer: assert property (@(posedge clk) disable iff (reset)
        $onehot0({div_wb.hi_en | div_wb.lo_en,
                  mul_wb.hi_en | mul_wb.lo_en,
                  move_wb.hi_en | move_wb.lo_en}))
    else
    begin
        fail_cnt++;
        $error("more than one write-back source active");
    end

endmodule

bind muldiv_unit muldiv_properties u_props
(
    .clk       (clk),
    .reset     (reset),
    .flush     (flush),
    .busy      (busy),
    .mul_start (mul_start),
    .div_start (div_start),
    .mul_wb    (mul_wb),
    .div_wb    (div_wb),
    .move_wb   (move_wb)
);

`default_nettype wire

/* verif/muldiv_tb.sv */
`default_nettype none

// testbench for the hi/lo multiply-divide unit
module muldiv_tb;

    localparam int clk_period   = 100;
    localparam int n_rand       = 16;                               // random ops per kind
    localparam int mul_cost     = muldiv_pkg::mul_stages + 8;       // issue, wait, two reads
    localparam int div_cost     = muldiv_pkg::div_steps + 2 + 8;
    localparam int flush_cost   = 2 * muldiv_pkg::div_steps + 12;   // longest delay, settle, reads
    localparam int idle_limit   = muldiv_pkg::div_steps + 10;       // longest busy plus slack
    localparam int total_cycles = 10 + 2 * n_rand * (mul_cost + div_cost)
                                  + 4 * flush_cost + 300;

    logic clk;
    logic reset;
    logic flush;
    logic rd_lo;
    logic busy;
    muldiv_pkg::md_req_t req;
    muldiv_pkg::word_t   rd_data;

    muldiv_pkg::word_t hi_exp;      // reference model state
    muldiv_pkg::word_t lo_exp;
    int err_cnt;
    int err_mark;                   // error total when the test began
    int test_cnt;
    int test_fail_cnt;
    int unused_seed;

    muldiv_unit u_muldiv_unit
    (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .flush   (flush),
        .rd_lo   (rd_lo),
        .busy    (busy),
        .rd_data (rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // watchdog
    initial
    begin
        #(total_cycles * clk_period);
        $display("watchdog expired, the run did not end within %0d cycles", total_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    // own checks plus the bound concurrent ones
    function automatic int total_errors();
        return err_cnt + u_muldiv_unit.u_props.fail_cnt;
    endfunction

    function automatic muldiv_pkg::word_t pick_operand();
        int unsigned sel;
        muldiv_pkg::word_t v;
        sel = $urandom % 8;
        v   = $urandom;
        case (sel)
            0: v = 32'h8000_0000;           // most negative word
            1: v = v >> ($urandom % 32);    // spread of magnitudes
            2: v = $urandom % 16;           // small, zero included
            default: ;
        endcase
        return v;
    endfunction

    // expected hi/lo straight from the operation rules
    task automatic model_apply(input muldiv_pkg::md_op_e op, input muldiv_pkg::word_t a,
                               input muldiv_pkg::word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        muldiv_pkg::dword_t p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        case (op)
            muldiv_pkg::op_mult:
            begin
                p = sa * sb;
                {hi_exp, lo_exp} = p;
            end
            muldiv_pkg::op_multu:
            begin
                p = {32'b0, a} * {32'b0, b};
                {hi_exp, lo_exp} = p;
            end
            muldiv_pkg::op_div:
            begin
                lo_exp = 32'(sa / sb);      // 64-bit so min / -1 does not overflow
                hi_exp = 32'(sa % sb);      // takes the dividend's sign
            end
            muldiv_pkg::op_divu:
            begin
                lo_exp = (b == 0) ? 32'hffff_ffff : a / b;
                hi_exp = (b == 0) ? a : a % b;
            end
            muldiv_pkg::op_mthi: hi_exp = a;
            muldiv_pkg::op_mtlo: lo_exp = a;
            default: ;
        endcase
    endtask

    // one cycle of valid, returns after the sampling edge
    task automatic issue(input muldiv_pkg::md_op_e op, input muldiv_pkg::word_t a,
                         input muldiv_pkg::word_t b);
        @(posedge clk);
        req <= {1'b1, op, a, b};
        @(posedge clk);
        req.valid <= 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < idle_limit)
        begin
            @(negedge clk);
            n++;
        end
        if (busy)
        begin
            $display("busy did not fall within %0d cycles, time %0t", idle_limit, $time);
            err_cnt++;
        end
    endtask

    // read both registers through rd_data, sampled mid-cycle
    task automatic check_hilo(input string what);
        muldiv_pkg::word_t hi_got;
        muldiv_pkg::word_t lo_got;
        @(posedge clk);
        rd_lo <= 1'b0;
        @(negedge clk);
        hi_got = rd_data;
        @(posedge clk);
        rd_lo <= 1'b1;
        @(negedge clk);
        lo_got = rd_data;
        assert (hi_got == hi_exp)
        else
        begin
            $display("error %0t: %s hi is %h, expected %h", $time, what, hi_got, hi_exp);
            err_cnt++;
        end
        assert (lo_got == lo_exp)
        else
        begin
            $display("error %0t: %s lo is %h, expected %h", $time, what, lo_got, lo_exp);
            err_cnt++;
        end
    endtask

    task automatic run_op(input muldiv_pkg::md_op_e op, input muldiv_pkg::word_t a,
                          input muldiv_pkg::word_t b);
        issue(op, a, b);
        model_apply(op, a, b);
        wait_idle();
        check_hilo($sformatf("%s %h %h", op.name(), a, b));
    endtask

    // the target register is read in the same cycle as the move request
    task automatic move_to(input muldiv_pkg::md_op_e op, input muldiv_pkg::word_t a);
        @(posedge clk);
        req   <= {1'b1, op, a, 32'h0};
        rd_lo <= (op == muldiv_pkg::op_mtlo);
        @(negedge clk);
        assert (rd_data == a)
        else
        begin
            $display("error %0t: pending %s not visible on read, got %h, expected %h",
                     $time, op.name(), rd_data, a);
            err_cnt++;
        end
        @(posedge clk);
        req.valid <= 1'b0;
        model_apply(op, a, '0);
        @(negedge clk);
        assert (!busy)
        else
        begin
            $display("error %0t: busy raised by %s", $time, op.name());
            err_cnt++;
        end
    endtask

    // start a mul or div, cancel it after a few cycles, old hi/lo must stay
    task automatic flush_after(input muldiv_pkg::md_op_e op, input int delay);
        issue(op, pick_operand(), 32'd3);   // never reaches the model
        repeat (delay) @(posedge clk);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        assert (!busy)
        else
        begin
            $display("error %0t: busy still high after flushing %s", $time, op.name());
            err_cnt++;
        end
        repeat (muldiv_pkg::div_steps + 4) @(posedge clk);   // a late write would land here
        check_hilo($sformatf("flushed %s", op.name()));
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (total_errors() == err_mark)
            $display("test %0d %s passed", test_cnt, name);
        else
        begin
            test_fail_cnt++;
            $display("test %0d %s failed, %0d errors", test_cnt, name, total_errors() - err_mark);
        end
        err_mark = total_errors();
    endtask

    initial
    begin
        muldiv_pkg::md_op_e op;
        muldiv_pkg::word_t  a;
        muldiv_pkg::word_t  b;
        unused_seed   = $urandom(32'h4ee0_5c41);
        reset         = 1'b1;
        flush         = 1'b0;
        rd_lo         = 1'b0;
        req           = '0;
        hi_exp        = '0;
        lo_exp        = '0;
        err_cnt       = 0;
        err_mark      = 0;
        test_cnt      = 0;
        test_fail_cnt = 0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        check_hilo("after reset");          // both cleared
        move_to(muldiv_pkg::op_mthi, $urandom);
        move_to(muldiv_pkg::op_mtlo, $urandom);
        check_hilo("moves");
        end_test("moves");

        run_op(muldiv_pkg::op_mult, 32'h8000_0000, 32'h8000_0000);
        run_op(muldiv_pkg::op_multu, 32'h8000_0000, 32'h8000_0000);
        run_op(muldiv_pkg::op_mult, 32'h8000_0000, 32'hffff_ffff);
        run_op(muldiv_pkg::op_multu, 32'hffff_ffff, 32'h8000_0000);
        for (int i = 0; i < n_rand; i++)
        begin
            op = ($urandom % 2) ? muldiv_pkg::op_mult : muldiv_pkg::op_multu;
            run_op(op, pick_operand(), pick_operand());
        end
        end_test("multiply");

        run_op(muldiv_pkg::op_divu, 32'h1234_5678, 32'h0);     // divide by zero
        run_op(muldiv_pkg::op_div, 32'hffff_fff9, 32'h2);      // -7 / 2
        run_op(muldiv_pkg::op_div, 32'h0000_0007, 32'hffff_fffe);
        run_op(muldiv_pkg::op_div, 32'h8000_0000, 32'hffff_ffff);
        for (int i = 0; i < n_rand; i++)
        begin
            op = ($urandom % 2) ? muldiv_pkg::op_div : muldiv_pkg::op_divu;
            a  = pick_operand();
            b  = pick_operand();
            if (op == muldiv_pkg::op_div && b == 0)
                b = 32'd1;                  // signed by zero left open
            run_op(op, a, b);
        end
        end_test("divide");

        a = pick_operand();
        b = pick_operand();
        issue(muldiv_pkg::op_div, a, 32'd7);
        rd_lo <= 1'b0;
        issue(muldiv_pkg::op_mthi, ~hi_exp, '0);  // dropped, unit busy
        @(negedge clk);
        assert (rd_data == hi_exp)          // old hi until the divide lands
        else
        begin
            $display("error %0t: hi is %h while the divide runs, expected %h",
                     $time, rd_data, hi_exp);
            err_cnt++;
        end
        model_apply(muldiv_pkg::op_div, a, 32'd7);
        wait_idle();
        check_hilo("div with move while busy");
        issue(muldiv_pkg::op_divu, a, 32'd7);
        model_apply(muldiv_pkg::op_divu, a, 32'd7);
        issue(muldiv_pkg::op_mult, b, b);
        wait_idle();
        check_hilo("divu with mult while busy");
        end_test("request while busy");

        move_to(muldiv_pkg::op_mthi, 32'hdead_0001);
        move_to(muldiv_pkg::op_mtlo, 32'hbeef_0002);
        flush_after(muldiv_pkg::op_mult, 1);                     // hits the write-back cycle
        flush_after(muldiv_pkg::op_divu, 10);
        flush_after(muldiv_pkg::op_div, muldiv_pkg::div_steps);  // hits the done cycle
        end_test("flush");

        $display("tests %0d, failed %0d, check errors %0d, property failures %0d",
                 test_cnt, test_fail_cnt, err_cnt, u_muldiv_unit.u_props.fail_cnt);
        if (test_fail_cnt == 0 && total_errors() == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
logic/muldiv_pkg.sv
logic/mul_pipe.sv
logic/radix2_divider.sv
logic/hilo_regs.sv
logic/muldiv_unit.sv
verif/muldiv_properties.sv
verif/muldiv_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the muldiv testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module muldiv_tb -o muldiv_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# let every assertion failure be counted instead of stopping at the first
./obj_dir/muldiv_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF "=== PASS ===" "$log"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, pass message not found in $log"
exit 1
